/* rv64_mmio_bus.f */
design/mmio_pkg.sv
design/key_irq_latch.sv
design/sector_buffer.sv
design/bus_decode_stage.sv
design/mem_access_stage.sv
design/load_align_stage.sv
design/rv64_mmio_bus.sv
sim/tb_rv64_mmio_bus.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module rv64_mmio_bus \
		design/mmio_pkg.sv design/key_irq_latch.sv design/sector_buffer.sv \
		design/bus_decode_stage.sv design/mem_access_stage.sv \
		design/load_align_stage.sv design/rv64_mmio_bus.sv
	verilator --lint-only --timing --top-module tb_rv64_mmio_bus -f rv64_mmio_bus.f

sim:
	verilator --binary --timing --assert --top-module tb_rv64_mmio_bus \
		-f rv64_mmio_bus.f -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_rv64_mmio_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv64_mmio_bus
    import mmio_pkg::*;
;

    localparam int          RAM_WORDS = 1024;
    localparam logic [31:0] SEED      = 32'hf5b7fb07;

    // Rough cycle budget of each test
    localparam int T_RESET  = 20;
    localparam int T_RAM    = 200;
    localparam int T_BYTES  = 300;
    localparam int T_DWORD  = 200;
    localparam int T_SD     = 2400;
    localparam int T_KEY    = 100;
    localparam int MARGIN   = 500;
    localparam int WATCH_CYCLES = T_RESET + T_RAM + T_BYTES + T_DWORD + T_SD + T_KEY + MARGIN;

    logic         CLOCK_50;
    logic         KEY0;
    logic [63:0]  bus_address;
    logic [63:0]  bus_write_data;
    logic         bus_read_enable;
    logic         bus_write_enable;
    access_size_e bus_read_type;
    access_size_e bus_write_type;
    logic [63:0]  bus_read_data;
    logic         bus_read_done;
    logic         bus_write_done;
    logic [7:0]   sd_byte;
    logic         sd_byte_available;
    logic         sd_ready;
    logic [31:0]  sd_sector;
    logic         sd_rd_start;
    logic         uart_tx_valid;
    logic [7:0]   uart_tx_data;
    logic [7:0]   key_code;
    logic         key_pressed;
    logic         irq_ack;
    logic [3:0]   irq_vector;

    // Expected events, indexed by cycle modulo 64
    logic         sched_rd [64];
    logic         sched_wr [64];
    logic [63:0]  sched_data [64];
    logic         sched_uart [64];
    logic [7:0]   sched_uart_byte [64];
    logic         sched_sd [64];

    logic [7:0]   ram_model [RAM_WORDS*4];
    logic [7:0]   sector_model [SECTOR_BYTES];
    logic [31:0]  cyc;
    logic [5:0]   now_slot;
    logic [3:0]   exp_irq;
    logic [31:0]  exp_sector;
    int           errors;
    int           errors_at_start;
    int           tests_run;
    int           tests_failed;

    rv64_mmio_bus #(.RAM_WORDS(RAM_WORDS)) rv64_mmio_bus_i (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    assign now_slot = cyc[5:0];

    // Retire the slot that was just checked
    always @(posedge CLOCK_50) begin
        sched_rd[now_slot]   <= 1'b0;
        sched_wr[now_slot]   <= 1'b0;
        sched_uart[now_slot] <= 1'b0;
        sched_sd[now_slot]   <= 1'b0;
        cyc <= cyc + 1;
    end

    // Keyboard interrupt model
    always @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            exp_irq <= 4'd0;
        end else begin
            if (key_pressed && key_code != 8'd0)
                exp_irq <= 4'd1;
            if (exp_irq != 4'd0 && irq_ack)
                exp_irq <= 4'd0;
        end
    end

    task automatic note_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    a_rd_done: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done == sched_rd[now_slot])
        else note_error("bus_read_done out of schedule");

    a_wr_done: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_done == sched_wr[now_slot])
        else note_error("bus_write_done out of schedule");

    a_rd_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done |-> bus_read_data == sched_data[now_slot])
        else note_error($sformatf("bus_read_data %h, expected %h",
            bus_read_data, sched_data[now_slot]));

    a_uart: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_tx_valid == sched_uart[now_slot])
        else note_error("uart_tx_valid out of schedule");

    a_uart_data: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_tx_valid |-> uart_tx_data == sched_uart_byte[now_slot])
        else note_error("uart_tx_data differs from the stored byte");

    a_sd_start: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start == sched_sd[now_slot])
        else note_error("sd_rd_start out of schedule");

    a_irq: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_vector == exp_irq)
        else note_error($sformatf("irq_vector %0d, expected %0d", irq_vector, exp_irq));

    // Outputs stay quiet while reset is held
    a_reset_quiet: assert property (@(posedge CLOCK_50) (!KEY0 && cyc > 1) |->
        (!bus_read_done && !bus_write_done && !uart_tx_valid && !sd_rd_start
         && irq_vector == 4'd0))
        else note_error("output active during reset");

    function automatic logic [63:0] load_expect(input int off, input access_size_e t);
        logic [63:0] b;
        for (int i = 0; i < 8; i++)
            b[8*i +: 8] = (off + i < RAM_WORDS*4) ? ram_model[off + i] : 8'h00;
        case (t)
            ACC_LB:  return {{56{b[7]}}, b[7:0]};
            ACC_LH:  return {{48{b[15]}}, b[15:0]};
            ACC_LW:  return {{32{b[31]}}, b[31:0]};
            ACC_LBU: return {56'd0, b[7:0]};
            ACC_LHU: return {48'd0, b[15:0]};
            ACC_LWU: return {32'd0, b[31:0]};
            default: return b;
        endcase
    endfunction

    task automatic go_idle();
        @(posedge CLOCK_50);
        bus_read_enable  <= 1'b0;
        bus_write_enable <= 1'b0;
    endtask

    task automatic issue_read(input logic [63:0] addr, input access_size_e t,
                              input logic [63:0] exp);
        logic [5:0] slot;
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_read_type    <= t;
        bus_read_enable  <= 1'b1;
        bus_write_enable <= 1'b0;
        slot = 6'(cyc + ((t == ACC_LD) ? 5 : 4));
        sched_rd[slot]   = 1'b1;
        sched_data[slot] = exp;
        // Gap cycle for the high beat
        if (t == ACC_LD)
            go_idle();
    endtask

    task automatic issue_write(input logic [63:0] addr, input access_size_e t,
                               input logic [63:0] data);
        logic [5:0] slot;
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_type   <= t;
        bus_write_data   <= data;
        bus_write_enable <= 1'b1;
        bus_read_enable  <= 1'b0;
        slot = 6'(cyc + ((t == ACC_SD) ? 5 : 4));
        sched_wr[slot] = 1'b1;
        if (addr == UART_ADDR) begin
            sched_uart[6'(cyc + 3)]      = 1'b1;
            sched_uart_byte[6'(cyc + 3)] = data[7:0];
        end
        if (addr == SD_READ_REG)
            sched_sd[6'(cyc + 3)] = 1'b1;
        if (t == ACC_SD)
            go_idle();
    endtask

    task automatic ram_write(input int off, input access_size_e t, input logic [63:0] data);
        int n;
        case (t)
            ACC_SB:  n = 1;
            ACC_SH:  n = 2;
            ACC_SW:  n = 4;
            default: n = 8;
        endcase
        for (int i = 0; i < n; i++)
            ram_model[off + i] = data[8*i +: 8];
        issue_write(RAM_BASE + 64'(off), t, data);
    endtask

    task automatic ram_read(input int off, input access_size_e t);
        issue_read(RAM_BASE + 64'(off), t, load_expect(off, t));
    endtask

    task automatic drain();
        go_idle();
        repeat (6) @(posedge CLOCK_50);
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        drain();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    function automatic int rand_word_off(input int last_word);
        return ($urandom % last_word) * 4;
    endfunction

    // Every load form that is legal inside one word
    task automatic all_loads(input int w);
        for (int o = 0; o < 4; o++) begin
            ram_read(w + o, ACC_LB);
            ram_read(w + o, ACC_LBU);
        end
        for (int o = 0; o < 4; o += 2) begin
            ram_read(w + o, ACC_LH);
            ram_read(w + o, ACC_LHU);
        end
        ram_read(w, ACC_LW);
        ram_read(w, ACC_LWU);
    endtask

    initial begin
        int w;
        void'($urandom(SEED));
        KEY0              = 1'b0;
        bus_address       = 64'd0;
        bus_write_data    = 64'd0;
        bus_read_enable   = 1'b0;
        bus_write_enable  = 1'b0;
        bus_read_type     = ACC_LW;
        bus_write_type    = ACC_SW;
        sd_byte           = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        key_code          = 8'd0;
        key_pressed       = 1'b0;
        irq_ack           = 1'b0;
        cyc               = 32'd0;
        exp_sector        = 32'd0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        for (int i = 0; i < 64; i++) begin
            sched_rd[i]   = 1'b0;
            sched_wr[i]   = 1'b0;
            sched_uart[i] = 1'b0;
            sched_sd[i]   = 1'b0;
        end
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        start_test();
        @(posedge CLOCK_50);
        assert (!bus_read_done && !bus_write_done && !uart_tx_valid && !sd_rd_start
                && irq_vector == 4'd0 && sd_sector == 32'd0)
            else note_error("output not cleared after reset");
        issue_read(SD_AVAIL_REG, ACC_LWU, 64'd0);
        finish_test("reset_state");

        start_test();
        for (int i = 0; i < 16; i++) begin
            w = rand_word_off(RAM_WORDS);
            ram_write(w, ACC_SW, {32'd0, $urandom});
            ram_read(w, ACC_LW);
        end
        finish_test("word_write_read");

        start_test();
        w = rand_word_off(RAM_WORDS);
        for (int o = 0; o < 4; o++) begin
            ram_write(w, ACC_SW, {32'd0, $urandom});
            ram_write(w + o, ACC_SB, {56'd0, 8'($urandom)});
            all_loads(w);
        end
        for (int o = 0; o < 4; o += 2) begin
            ram_write(w, ACC_SW, {32'd0, $urandom});
            ram_write(w + o, ACC_SH, {48'd0, 16'($urandom)});
            all_loads(w);
        end
        finish_test("byte_half_extend");

        start_test();
        for (int i = 0; i < 8; i++) begin
            w = rand_word_off(RAM_WORDS - 1);
            ram_write(w, ACC_SD, {$urandom, $urandom});
            ram_read(w, ACC_LD);
        end
        w = rand_word_off(RAM_WORDS - 8);
        for (int i = 0; i < 8; i++)
            ram_write(w + 4*i, ACC_SW, {32'd0, $urandom});
        for (int i = 0; i < 8; i++)
            ram_read(w + 4*i, ACC_LW);
        finish_test("dword_and_stream");

        start_test();
        exp_sector = $urandom;
        issue_write(SD_ADDR_REG, ACC_SW, {32'd0, exp_sector});
        issue_write(SD_READ_REG, ACC_SW, 64'd1);
        drain();
        assert (sd_sector == exp_sector) else note_error("sd_sector not loaded");
        issue_read(SD_AVAIL_REG, ACC_LWU, 64'd0);
        go_idle();
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            sector_model[i] = 8'($urandom);
            @(posedge CLOCK_50);
            sd_byte           <= sector_model[i];
            sd_byte_available <= 1'b1;
            @(posedge CLOCK_50);
            sd_byte_available <= 1'b0;
        end
        issue_read(SD_AVAIL_REG, ACC_LWU, 64'd1);
        for (int i = 0; i < SECTOR_BYTES; i += 37)
            issue_read(SD_CACHE_BASE + 64'(i), ACC_LBU, {56'd0, sector_model[i]});
        issue_read(SD_CACHE_BASE + 64'(SECTOR_BYTES - 1), ACC_LBU,
                   {56'd0, sector_model[SECTOR_BYTES - 1]});
        issue_write(SD_READ_REG, ACC_SW, 64'd1);
        drain();
        issue_read(SD_AVAIL_REG, ACC_LWU, 64'd0);
        go_idle();
        sd_ready <= 1'b1;
        issue_read(SD_READY_REG, ACC_LWU, 64'd1);
        go_idle();
        // Ready level is sampled two edges after the strobe
        @(posedge CLOCK_50);
        sd_ready <= 1'b0;
        issue_read(SD_READY_REG, ACC_LWU, 64'd0);
        drain();
        assert (sd_sector == exp_sector) else note_error("sd_sector lost after read start");
        finish_test("sd_sector_path");

        start_test();
        @(posedge CLOCK_50);
        key_code    <= 8'h5a;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        repeat (2) @(posedge CLOCK_50);
        issue_read(KEY_ADDR, ACC_LBU, 64'h5a);
        drain();
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        issue_write(UART_ADDR, ACC_SB, 64'h1234_5678_9abc_dea7);
        finish_test("key_and_uart");

        $display("tests run %0d, failed %0d, assertion errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * 8);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* design/rv64_mmio_bus.sv */
`timescale 1ns/1ns
`default_nettype none

module rv64_mmio_bus
    import mmio_pkg::*;
#(
    parameter int RAM_WORDS = 1024
) (
    input  wire                CLOCK_50,
    input  wire                KEY0,
    input  wire         [63:0] bus_address,
    input  wire         [63:0] bus_write_data,
    input  wire                bus_read_enable,
    input  wire                bus_write_enable,
    input  wire  access_size_e bus_read_type,
    input  wire  access_size_e bus_write_type,
    output logic        [63:0] bus_read_data,
    output logic               bus_read_done,
    output logic               bus_write_done,
    input  wire          [7:0] sd_byte,
    input  wire                sd_byte_available,
    input  wire                sd_ready,
    output logic        [31:0] sd_sector,
    output logic               sd_rd_start,
    output logic               uart_tx_valid,
    output logic         [7:0] uart_tx_data,
    input  wire          [7:0] key_code,
    input  wire                key_pressed,
    input  wire                irq_ack,
    output logic         [3:0] irq_vector
);

    localparam int IDX_W = beat_index_width(RAM_WORDS);

    // Decode to memory access
    logic             beat_valid;
    logic             beat_write;
    region_e          beat_region;
    logic [IDX_W-1:0] beat_index;
    logic [1:0]       beat_byte_off;
    access_size_e     beat_size;
    logic [31:0]      beat_wdata;
    logic             beat_hi;
    logic             beat_last;

    // Memory access to load align
    logic             resp_valid;
    logic             resp_write;
    logic             resp_last;
    logic             resp_hi;
    logic             resp_raw;
    access_size_e     resp_size;
    logic [1:0]       resp_byte_off;
    logic [31:0]      resp_rdata;

    // Device side
    logic [$clog2(SECTOR_BYTES)-1:0] cache_index;
    logic [7:0]       cache_byte;
    logic             sector_avail;
    logic [7:0]       key_code_q;

    bus_decode_stage #(.RAM_WORDS(RAM_WORDS)) bus_decode_stage_i (.*);

    mem_access_stage #(.RAM_WORDS(RAM_WORDS)) mem_access_stage_i (.*);

    load_align_stage load_align_stage_i (.*);

    sector_buffer sector_buffer_i (.*);

    key_irq_latch key_irq_latch_i (.*);

endmodule

`default_nettype wire

/* design/load_align_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module load_align_stage
    import mmio_pkg::*;
(
    input  wire                CLOCK_50,
    input  wire                KEY0,
    input  wire                resp_valid,
    input  wire                resp_write,
    input  wire                resp_last,
    input  wire                resp_hi,
    input  wire                resp_raw,
    input  wire  access_size_e resp_size,
    input  wire          [1:0] resp_byte_off,
    input  wire         [31:0] resp_rdata,
    output logic        [63:0] bus_read_data,
    output logic               bus_read_done,
    output logic               bus_write_done
);

    logic        rd_beat;
    logic [31:0] shifted;
    logic [63:0] extended;
    logic [31:0] lo_word;

    assign rd_beat = resp_valid & ~resp_write;
    assign shifted = resp_rdata >> {resp_byte_off, 3'b000};

    always_comb begin
        case (resp_size)
            ACC_LB:  extended = {{56{shifted[7]}}, shifted[7:0]};
            ACC_LH:  extended = {{48{shifted[15]}}, shifted[15:0]};
            ACC_LW:  extended = {{32{shifted[31]}}, shifted};
            ACC_LBU: extended = {56'd0, shifted[7:0]};
            ACC_LHU: extended = {48'd0, shifted[15:0]};
            default: extended = {32'd0, shifted};
        endcase
        // Device registers come back as is
        if (resp_raw)
            extended = {32'd0, resp_rdata};
    end

    always_ff @(posedge CLOCK_50) begin
        // Low half of a doubleword waits for its partner
        if (rd_beat && !resp_last)
            lo_word <= resp_rdata;
        if (rd_beat && resp_last)
            bus_read_data <= resp_hi ? {resp_rdata, lo_word} : extended;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b0;
            bus_write_done <= 1'b0;
        end else begin
            bus_read_done  <= rd_beat & resp_last;
            bus_write_done <= resp_valid & resp_write & resp_last;
        end
    end

    // A split request always brings its high beat on the next cycle
    a_hi_follows: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (resp_valid && !resp_last) |=> (resp_valid && resp_hi && resp_last));

endmodule

`default_nettype wire

/* design/mem_access_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_access_stage
    import mmio_pkg::*;
#(
    parameter int RAM_WORDS = 1024,
    localparam int IDX_W = beat_index_width(RAM_WORDS)
) (
    input  wire                CLOCK_50,
    input  wire                KEY0,
    input  wire                beat_valid,
    input  wire                beat_write,
    input  wire  region_e      beat_region,
    input  wire    [IDX_W-1:0] beat_index,
    input  wire          [1:0] beat_byte_off,
    input  wire  access_size_e beat_size,
    input  wire         [31:0] beat_wdata,
    input  wire                beat_hi,
    input  wire                beat_last,
    input  wire          [7:0] cache_byte,
    input  wire                sector_avail,
    input  wire          [7:0] key_code_q,
    input  wire                sd_ready,
    output logic               resp_valid,
    output logic               resp_write,
    output logic               resp_last,
    output logic               resp_hi,
    output logic               resp_raw,
    output access_size_e       resp_size,
    output logic         [1:0] resp_byte_off,
    output logic        [31:0] resp_rdata,
    output logic [$clog2(SECTOR_BYTES)-1:0] cache_index,
    output logic        [31:0] sd_sector,
    output logic               sd_rd_start,
    output logic               uart_tx_valid,
    output logic         [7:0] uart_tx_data
);

    localparam int AW     = $clog2(RAM_WORDS);
    localparam int CIDX_W = $clog2(SECTOR_BYTES);

    logic [31:0]   ram [RAM_WORDS];
    logic [AW-1:0] ram_addr;
    logic          ram_we;
    logic          dev_wr;
    logic [3:0]    lane_en;
    logic [31:0]   lane_data;
    logic [31:0]   ram_q;
    logic [31:0]   dev_q;
    logic          resp_cache;

    assign ram_addr    = beat_index[AW-1:0];
    assign cache_index = beat_index[CIDX_W-1:0];
    assign ram_we      = beat_valid & beat_write & (beat_region == REG_RAM);
    assign dev_wr      = beat_valid & beat_write & ~beat_hi;

    // Byte lanes for the store size
    always_comb begin
        case (beat_size)
            ACC_SB: begin
                lane_en   = 4'b0001 << beat_byte_off;
                lane_data = {4{beat_wdata[7:0]}};
            end
            ACC_SH: begin
                lane_en   = 4'b0011 << beat_byte_off;
                lane_data = {2{beat_wdata[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = beat_wdata;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        for (int i = 0; i < 4; i++) begin
            if (ram_we && lane_en[i])
                ram[ram_addr][8*i +: 8] <= lane_data[8*i +: 8];
        end
        ram_q <= ram[ram_addr];
    end

    always_ff @(posedge CLOCK_50) begin
        if (beat_valid && !beat_write) begin
            case (beat_region)
                REG_KEY:      dev_q <= {24'd0, key_code_q};
                REG_SD_READY: dev_q <= {31'd0, sd_ready};
                REG_SD_AVAIL: dev_q <= {31'd0, sector_avail};
                default:      dev_q <= 32'd0;
            endcase
        end
        if (dev_wr && beat_region == REG_UART)
            uart_tx_data <= beat_wdata[7:0];
        resp_write    <= beat_write;
        resp_last     <= beat_last;
        resp_hi       <= beat_hi;
        resp_raw      <= (beat_region != REG_RAM);
        resp_cache    <= (beat_region == REG_SD_CACHE);
        resp_size     <= beat_size;
        resp_byte_off <= beat_byte_off;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            resp_valid    <= 1'b0;
            sd_sector     <= 32'd0;
            sd_rd_start   <= 1'b0;
            uart_tx_valid <= 1'b0;
        end else begin
            resp_valid    <= beat_valid;
            sd_rd_start   <= dev_wr & (beat_region == REG_SD_READ);
            uart_tx_valid <= dev_wr & (beat_region == REG_UART);
            if (dev_wr && beat_region == REG_SD_ADDR)
                sd_sector <= beat_wdata;
        end
    end

    // Sector byte arrives from the buffer together with the response
    assign resp_rdata = !resp_raw   ? ram_q :
                        resp_cache  ? {24'd0, cache_byte} : dev_q;

    a_region_known: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        beat_valid |-> beat_region != REG_NONE);

endmodule

`default_nettype wire

/* design/bus_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_decode_stage
    import mmio_pkg::*;
#(
    parameter int RAM_WORDS = 1024,
    localparam int IDX_W = beat_index_width(RAM_WORDS)
) (
    input  wire                CLOCK_50,
    input  wire                KEY0,
    input  wire         [63:0] bus_address,
    input  wire         [63:0] bus_write_data,
    input  wire                bus_read_enable,
    input  wire                bus_write_enable,
    input  wire  access_size_e bus_read_type,
    input  wire  access_size_e bus_write_type,
    output logic               beat_valid,
    output logic               beat_write,
    output region_e            beat_region,
    output logic   [IDX_W-1:0] beat_index,
    output logic         [1:0] beat_byte_off,
    output access_size_e       beat_size,
    output logic        [31:0] beat_wdata,
    output logic               beat_hi,
    output logic               beat_last
);

    localparam int          CIDX_W    = $clog2(SECTOR_BYTES);
    localparam logic [63:0] RAM_END   = RAM_BASE + 64'(RAM_WORDS) * 64'd4;
    localparam logic [63:0] CACHE_END = SD_CACHE_BASE + 64'(SECTOR_BYTES);

    logic             strobe;
    access_size_e     req_size;
    region_e          req_region;
    logic [IDX_W-1:0] req_index;
    logic             req_aligned;
    logic             pend_hi;
    logic [31:0]      hi_wdata;

    assign strobe   = bus_read_enable | bus_write_enable;
    assign req_size = bus_write_enable ? bus_write_type : bus_read_type;

    always_comb begin
        if (bus_address >= RAM_BASE && bus_address < RAM_END)
            req_region = REG_RAM;
        else if (bus_address >= SD_CACHE_BASE && bus_address < CACHE_END)
            req_region = REG_SD_CACHE;
        else if (bus_address == KEY_ADDR)
            req_region = REG_KEY;
        else if (bus_address == UART_ADDR)
            req_region = REG_UART;
        else if (bus_address == SD_ADDR_REG)
            req_region = REG_SD_ADDR;
        else if (bus_address == SD_READ_REG)
            req_region = REG_SD_READ;
        else if (bus_address == SD_READY_REG)
            req_region = REG_SD_READY;
        else if (bus_address == SD_AVAIL_REG)
            req_region = REG_SD_AVAIL;
        else
            req_region = REG_NONE;
    end

    // Word index into RAM, otherwise byte index into the sector window
    always_comb begin
        if (req_region == REG_RAM)
            req_index = IDX_W'(bus_address[IDX_W+1:2] - RAM_BASE[IDX_W+1:2]);
        else
            req_index = IDX_W'(bus_address[CIDX_W-1:0] - SD_CACHE_BASE[CIDX_W-1:0]);
    end

    always_comb begin
        case (req_size)
            ACC_LB, ACC_LBU: req_aligned = 1'b1;
            ACC_LH, ACC_LHU: req_aligned = ~bus_address[0];
            default:         req_aligned = (bus_address[1:0] == 2'b00);
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_valid <= 1'b0;
            pend_hi    <= 1'b0;
        end else begin
            beat_valid <= strobe | pend_hi;
            pend_hi    <= strobe & (req_size == ACC_LD);
        end
    end

    // Second beat of a doubleword keeps region, size and direction
    always_ff @(posedge CLOCK_50) begin
        if (strobe) begin
            beat_write    <= bus_write_enable;
            beat_region   <= req_region;
            beat_index    <= req_index;
            beat_byte_off <= bus_address[1:0];
            beat_size     <= req_size;
            beat_wdata    <= bus_write_data[31:0];
            hi_wdata      <= bus_write_data[63:32];
            beat_hi       <= 1'b0;
            beat_last     <= (req_size != ACC_LD);
        end else if (pend_hi) begin
            beat_index <= beat_index + 1'b1;
            beat_wdata <= hi_wdata;
            beat_hi    <= 1'b1;
            beat_last  <= 1'b1;
        end
    end

    a_one_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

    // Requester leaves a gap after ld and sd
    a_no_strobe_hi: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        pend_hi |-> !strobe);

    a_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        strobe |-> req_aligned);

endmodule

`default_nettype wire

/* design/sector_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module sector_buffer
    import mmio_pkg::*;
(
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire  [7:0] sd_byte,
    input  wire        sd_byte_available,
    input  wire        sd_rd_start,
    input  wire  [$clog2(SECTOR_BYTES)-1:0] cache_index,
    output logic [7:0] cache_byte,
    output logic       sector_avail
);

    localparam int CIDX_W = $clog2(SECTOR_BYTES);

    logic [7:0]        mem [SECTOR_BYTES];
    logic [CIDX_W-1:0] wr_index;
    logic              avail_d;
    logic              byte_rise;

    // One byte per rising edge of the controller's strobe
    assign byte_rise = sd_byte_available & ~avail_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            avail_d      <= 1'b0;
            wr_index     <= '0;
            sector_avail <= 1'b0;
        end else begin
            avail_d <= sd_byte_available;
            if (byte_rise) begin
                if (wr_index == CIDX_W'(SECTOR_BYTES - 1)) begin
                    wr_index     <= '0;
                    sector_avail <= 1'b1;
                end else begin
                    wr_index <= wr_index + 1'b1;
                end
            end
            // New sector request restarts the fill
            if (sd_rd_start) begin
                wr_index     <= '0;
                sector_avail <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_rise)
            mem[wr_index] <= sd_byte;
        cache_byte <= mem[cache_index];
    end

    a_no_overfill: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        byte_rise |-> !sector_avail);

endmodule

`default_nettype wire

/* design/key_irq_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module key_irq_latch (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire  [7:0] key_code,
    input  wire        key_pressed,
    input  wire        irq_ack,
    output logic [7:0] key_code_q,
    output logic [3:0] irq_vector
);

    logic key_event;

    // Code 0 means no printable key
    assign key_event = key_pressed & (key_code != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code_q <= 8'd0;
            irq_vector <= 4'd0;
        end else begin
            if (key_event) begin
                key_code_q <= key_code;
                irq_vector <= 4'd1;
            end
            // Acknowledge wins over a press in the same cycle
            if (irq_vector != 4'd0 && irq_ack)
                irq_vector <= 4'd0;
        end
    end

endmodule

`default_nettype wire

/* design/mmio_pkg.sv */
`default_nettype none

package mmio_pkg;

    // Address map
    localparam logic [63:0] RAM_BASE      = 64'h0000_0000_0000_2000;
    localparam logic [63:0] KEY_ADDR      = 64'h0000_0000_1000_0000;
    localparam logic [63:0] UART_ADDR     = 64'h0000_0000_1000_0008;
    localparam logic [63:0] SD_ADDR_REG   = 64'h0000_0000_1000_0010;
    localparam logic [63:0] SD_READ_REG   = 64'h0000_0000_1000_0018;
    localparam logic [63:0] SD_READY_REG  = 64'h0000_0000_1000_0020;
    localparam logic [63:0] SD_AVAIL_REG  = 64'h0000_0000_1000_0028;
    localparam logic [63:0] SD_CACHE_BASE = 64'h0000_0000_1000_1000;
    localparam int          SECTOR_BYTES  = 512;

    // Load and store types in funct3 coding
    typedef enum logic [2:0] {
        ACC_LB  = 3'b000,
        ACC_LH  = 3'b001,
        ACC_LW  = 3'b010,
        ACC_LD  = 3'b011,
        ACC_LBU = 3'b100,
        ACC_LHU = 3'b101,
        ACC_LWU = 3'b110
    } access_size_e;

    // Stores reuse the signed load codes
    localparam access_size_e ACC_SB = ACC_LB;
    localparam access_size_e ACC_SH = ACC_LH;
    localparam access_size_e ACC_SW = ACC_LW;
    localparam access_size_e ACC_SD = ACC_LD;

    typedef enum logic [3:0] {
        REG_NONE,
        REG_RAM,
        REG_KEY,
        REG_UART,
        REG_SD_ADDR,
        REG_SD_READ,
        REG_SD_READY,
        REG_SD_CACHE,
        REG_SD_AVAIL
    } region_e;

    // Wide enough for a RAM word index or a sector byte index
    function automatic int beat_index_width(input int ram_words);
        int ram_w;
        ram_w = $clog2(ram_words);
        return (ram_w > $clog2(SECTOR_BYTES)) ? ram_w : $clog2(SECTOR_BYTES);
    endfunction

endpackage

`default_nettype wire
